/* io_config.svh */
/*
 * I/O subsystem configuration
 * Core, thread and event counts plus base addresses of the internal
 * devices on the non-cacheable I/O bus
 */
`ifndef IO_CONFIG_SVH
`define IO_CONFIG_SVH

// Requesting cores and their hardware threads
`define NUM_CORES 4
`define THREADS_PER_CORE 2
`define TOTAL_THREADS (`NUM_CORES * `THREADS_PER_CORE)

// Must hold any index below NUM_CORES
`define CORE_ID_WIDTH 2

// One counter per event line
`define NUM_PERF_EVENTS 4

// Interrupt controller, enable mask at base, pending mask at base + 4
`define IC_BASE_ADDRESS 'h60

// Counter i sits at base + 4 * i
`define PERF_BASE_ADDRESS 'h120

`endif

/* io_pkg.sv */
/*
 * I/O package
 * Data word, core index and request/response packet types shared by
 * the arbiter, the devices and the top level
 */
`include "io_config.svh"

package io_pkg;

	// One data or address word
	typedef logic [31:0] scalar_t;

	typedef logic [`CORE_ID_WIDTH-1:0] core_id_t;

	// Non-cacheable request from one core
	typedef struct packed {
		logic valid;
		logic store;
		scalar_t address;
		scalar_t write_data;
	} ioreq_packet_t;

	// Shared response, tagged with the requesting core
	typedef struct packed {
		logic valid;
		core_id_t core;
		scalar_t read_value;
	} iorsp_packet_t;

	// Which device answers the current read
	typedef enum logic [1:0] {
		IO_PERF_COUNTERS,
		IO_INT_CONTROLLER,
		IO_EXTERNAL
	} io_read_source_t;

endpackage

/* io_bus_if.sv */
/*
 * Internal I/O bus
 * Single-cycle read and write strobes from the arbiter to the devices,
 * with the muxed read data returned to the arbiter
 */
`timescale 1ns/1ps

interface io_bus_if;

	import io_pkg::*;

	logic write_en;
	logic read_en;
	scalar_t address;
	scalar_t write_data;
	// Driven by the top-level read mux
	scalar_t read_data;

	modport master(
		output write_en,
		output read_en,
		output address,
		output write_data,
		input read_data);

	// Devices answer on their own ports
	modport device(
		input write_en,
		input read_en,
		input address,
		input write_data);

endinterface

/* io_arbiter.sv */
/*
 * I/O arbiter
 * Round-robin choice among core non-cacheable requests, one bus cycle
 * per grant, response returned to the granted core a cycle later
 */
`timescale 1ns/1ps
`include "io_config.svh"

module io_arbiter(
	input clk,
	input rst_n,
	input io_pkg::ioreq_packet_t io_request[`NUM_CORES],
	output logic [`NUM_CORES-1:0] ia_ready,
	output io_pkg::iorsp_packet_t ia_response,
	io_bus_if.master io_bus);

	import io_pkg::*;

	core_id_t last_granted;
	core_id_t grant_idx;
	logic grant_valid;
	logic bus_active;
	logic accept;
	logic [`NUM_CORES-1:0] grant_oh;
	logic response_pending;
	logic response_store;
	core_id_t response_core;

	// Bus cycle in flight, hold off until the response cycle
	assign bus_active = io_bus.write_en || io_bus.read_en;
	assign accept = grant_valid && !bus_active;

	// First valid core after the last granted one
	always_comb
	begin
		int idx;

		grant_valid = 1'b0;
		grant_idx = last_granted;
		// Walk down so the nearest core wins
		for (int i = `NUM_CORES; i >= 1; i--)
		begin
			idx = (int'(last_granted) + i) % `NUM_CORES;
			if (io_request[idx].valid)
			begin
				grant_valid = 1'b1;
				grant_idx = core_id_t'(idx);
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < `NUM_CORES; i++)
			grant_oh[i] = accept && (grant_idx == core_id_t'(i));
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ia_ready <= '0;
			io_bus.write_en <= 1'b0;
			io_bus.read_en <= 1'b0;
			last_granted <= '0;
			response_pending <= 1'b0;
		end
		else
		begin
			// Ready pulse lines up with the bus strobe
			ia_ready <= grant_oh;
			io_bus.write_en <= accept && io_request[grant_idx].store;
			io_bus.read_en <= accept && !io_request[grant_idx].store;
			if (accept)
				last_granted <= grant_idx;
			response_pending <= bus_active;
		end
	end

	// Request payload and response tag
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			io_bus.address <= io_request[grant_idx].address;
			io_bus.write_data <= io_request[grant_idx].write_data;
		end
		response_store <= io_bus.write_en;
		response_core <= last_granted;
	end

	// Device data arrives in the response cycle itself
	always_comb
	begin
		ia_response.valid = response_pending;
		ia_response.core = response_core;
		ia_response.read_value = response_store ? '0 : io_bus.read_data;
	end

	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ia_ready));

	// At most one transaction every two cycles
	assert property (@(posedge clk) disable iff (!rst_n)
		(io_bus.write_en || io_bus.read_en) |=> !(io_bus.write_en || io_bus.read_en));

endmodule

/* interrupt_controller.sv */
/*
 * Interrupt controller
 * Per-thread pending state gated by a writable enable mask, cleared by
 * the threads' acknowledge lines, both masks readable over the I/O bus
 */
`timescale 1ns/1ps
`include "io_config.svh"

module interrupt_controller(
	input clk,
	input rst_n,
	io_bus_if.device io_bus,
	output io_pkg::scalar_t io_read_data,
	input [`TOTAL_THREADS-1:0] interrupt_req,
	input [`TOTAL_THREADS-1:0] wb_interrupt_ack,
	output logic [`TOTAL_THREADS-1:0] ic_thread_en,
	output logic [`TOTAL_THREADS-1:0] ic_interrupt_pending);

	import io_pkg::*;

	localparam scalar_t ENABLE_ADDRESS = scalar_t'(`IC_BASE_ADDRESS);
	localparam scalar_t PENDING_ADDRESS = scalar_t'(`IC_BASE_ADDRESS + 4);

	logic [`TOTAL_THREADS-1:0] pending_next;

	// Ack wins over a new request in the same cycle
	assign pending_next = (ic_interrupt_pending | (interrupt_req & ic_thread_en))
		& ~wb_interrupt_ack;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			// All threads enabled out of reset
			ic_thread_en <= '1;
			ic_interrupt_pending <= '0;
		end
		else
		begin
			if (io_bus.write_en && io_bus.address == ENABLE_ADDRESS)
				ic_thread_en <= io_bus.write_data[`TOTAL_THREADS-1:0];
			ic_interrupt_pending <= pending_next;
		end
	end

	// Read data valid the cycle after read_en
	always_ff @(posedge clk)
	begin
		if (io_bus.read_en)
		begin
			case (io_bus.address)
				ENABLE_ADDRESS: io_read_data <= scalar_t'(ic_thread_en);
				PENDING_ADDRESS: io_read_data <= scalar_t'(ic_interrupt_pending);
				default: io_read_data <= '0;
			endcase
		end
	end

	// Arbiter issues only one kind of strobe per cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		!(io_bus.read_en && io_bus.write_en));

endmodule

/* performance_counters.sv */
/*
 * Performance counters
 * One free-running 32-bit counter per event line, each readable at
 * its own word address on the I/O bus
 */
`timescale 1ns/1ps
`include "io_config.svh"

module performance_counters(
	input clk,
	input rst_n,
	io_bus_if.device io_bus,
	input [`NUM_PERF_EVENTS-1:0] perf_events,
	output io_pkg::scalar_t io_read_data);

	import io_pkg::*;

	localparam scalar_t BASE_ADDRESS = scalar_t'(`PERF_BASE_ADDRESS);

	scalar_t event_count[`NUM_PERF_EVENTS];
	scalar_t read_value;

	// Count every cycle the line is high, visible a cycle later
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `NUM_PERF_EVENTS; i++)
				event_count[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < `NUM_PERF_EVENTS; i++)
			begin
				if (perf_events[i])
					event_count[i] <= event_count[i] + 1'b1;
			end
		end
	end

	// Address decode, unknown offsets read as zero
	always_comb
	begin
		read_value = '0;
		for (int i = 0; i < `NUM_PERF_EVENTS; i++)
		begin
			if (io_bus.address == BASE_ADDRESS + scalar_t'(4 * i))
				read_value = event_count[i];
		end
	end

	// Writes from the bus have no effect here
	always_ff @(posedge clk)
	begin
		if (io_bus.read_en)
			io_read_data <= read_value;
	end

endmodule

/* io_subsystem.sv */
/*
 * I/O subsystem top level
 * Joins the core request ports to the I/O arbiter, interrupt controller
 * and performance counters, mirrors the bus to external devices and
 * selects which device supplies read data
 */
`timescale 1ns/1ps
`include "io_config.svh"

module io_subsystem(
	input clk,
	input rst_n,

	// Core request ports, one slice per core
	input [`NUM_CORES-1:0] ior_valid,
	input [`NUM_CORES-1:0] ior_store,
	input [`NUM_CORES*32-1:0] ior_address,
	input [`NUM_CORES*32-1:0] ior_write_data,
	output logic [`NUM_CORES-1:0] ia_ready,
	output logic ia_response_valid,
	output io_pkg::core_id_t ia_response_core,
	output io_pkg::scalar_t ia_response_data,

	// Interrupts and events
	input [`TOTAL_THREADS-1:0] interrupt_req,
	input [`TOTAL_THREADS-1:0] interrupt_ack,
	output logic [`TOTAL_THREADS-1:0] thread_en,
	output logic [`TOTAL_THREADS-1:0] interrupt_pending,
	input [`NUM_PERF_EVENTS-1:0] perf_events,

	// External device bus
	output logic io_write_en,
	output logic io_read_en,
	output io_pkg::scalar_t io_address,
	output io_pkg::scalar_t io_write_data,
	input io_pkg::scalar_t io_read_data);

	import io_pkg::*;

	localparam scalar_t PERF_LO = scalar_t'(`PERF_BASE_ADDRESS);
	localparam scalar_t PERF_HI = scalar_t'(`PERF_BASE_ADDRESS + 4 * `NUM_PERF_EVENTS);
	localparam scalar_t IC_LO = scalar_t'(`IC_BASE_ADDRESS);
	localparam scalar_t IC_HI = scalar_t'(`IC_BASE_ADDRESS + 8);

	ioreq_packet_t io_request[`NUM_CORES];
	iorsp_packet_t ia_response;
	scalar_t ic_io_read_data;
	scalar_t perf_io_read_data;
	io_read_source_t io_read_source;

	io_bus_if io_bus();

	initial
	begin
		assert (`NUM_CORES >= 1 && `NUM_CORES <= (1 << `CORE_ID_WIDTH));
	end

	// Pack flat core ports into request packets
	for (genvar core_idx = 0; core_idx < `NUM_CORES; core_idx++)
	begin : core_req_gen
		assign io_request[core_idx].valid = ior_valid[core_idx];
		assign io_request[core_idx].store = ior_store[core_idx];
		assign io_request[core_idx].address = ior_address[core_idx*32 +: 32];
		assign io_request[core_idx].write_data = ior_write_data[core_idx*32 +: 32];
	end

	io_arbiter u_io_arbiter(
		.clk(clk),
		.rst_n(rst_n),
		.io_request(io_request),
		.ia_ready(ia_ready),
		.ia_response(ia_response),
		.io_bus(io_bus));

	interrupt_controller u_interrupt_controller(
		.clk(clk),
		.rst_n(rst_n),
		.io_bus(io_bus),
		.io_read_data(ic_io_read_data),
		.interrupt_req(interrupt_req),
		.wb_interrupt_ack(interrupt_ack),
		.ic_thread_en(thread_en),
		.ic_interrupt_pending(interrupt_pending));

	performance_counters u_performance_counters(
		.clk(clk),
		.rst_n(rst_n),
		.io_bus(io_bus),
		.perf_events(perf_events),
		.io_read_data(perf_io_read_data));

	// Decode one cycle ahead, lines up with the returned data
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			io_read_source <= IO_EXTERNAL;
		else if (io_bus.address >= PERF_LO && io_bus.address < PERF_HI)
			io_read_source <= IO_PERF_COUNTERS;
		else if (io_bus.address >= IC_LO && io_bus.address < IC_HI)
			io_read_source <= IO_INT_CONTROLLER;
		else
			io_read_source <= IO_EXTERNAL;
	end

	always_comb
	begin
		case (io_read_source)
			IO_PERF_COUNTERS: io_bus.read_data = perf_io_read_data;
			IO_INT_CONTROLLER: io_bus.read_data = ic_io_read_data;
			default: io_bus.read_data = io_read_data;
		endcase
	end

	// Every access also strobes the external bus
	assign io_write_en = io_bus.write_en;
	assign io_read_en = io_bus.read_en;
	assign io_address = io_bus.address;
	assign io_write_data = io_bus.write_data;

	assign ia_response_valid = ia_response.valid;
	assign ia_response_core = ia_response.core;
	assign ia_response_data = ia_response.read_value;

endmodule

/* io_subsystem_tb.sv */
/*
 * I/O subsystem testbench
 * Plays four cores and an external device, drives interrupt and event
 * lines, and checks bus cycles and responses with concurrent assertions
 */
`timescale 1ns/1ps
`include "io_config.svh"

module io_subsystem_tb;

	import io_pkg::*;

	// Whole run takes under 1000 cycles
	localparam int MAX_CYCLES = 3000;
	localparam int PERF_CYCLES = 200;
	localparam int FAIR_ROUNDS = 8;
	localparam scalar_t DEVICE_PATTERN = 32'hA5A5_0000;

	logic clk = 1'b0;
	logic rst_n;
	logic [`NUM_CORES-1:0] ior_valid, ior_store, ia_ready;
	logic [`NUM_CORES*32-1:0] ior_address, ior_write_data;
	logic ia_response_valid;
	core_id_t ia_response_core;
	scalar_t ia_response_data;
	logic [`TOTAL_THREADS-1:0] interrupt_req, interrupt_ack, thread_en, interrupt_pending;
	logic [`NUM_PERF_EVENTS-1:0] perf_events;
	logic io_write_en, io_read_en;
	scalar_t io_address, io_write_data, io_read_data;

	int seed = 29;
	int errors = 0;
	int cycle_count = 0;
	// Expected read values, one queue per core
	scalar_t expected_q[`NUM_CORES][$];
	// Request each core last raised
	logic issued_store[`NUM_CORES];
	scalar_t issued_addr[`NUM_CORES];
	scalar_t issued_data[`NUM_CORES];
	core_id_t ready_core;
	core_id_t next_grant = core_id_t'(1);
	logic rsp_known = 1'b0;
	scalar_t exp_data = '0;
	logic fairness_on = 1'b0;
	logic ic_check = 1'b0;
	logic [`TOTAL_THREADS-1:0] exp_pending = '0;
	logic [`TOTAL_THREADS-1:0] exp_mask = '0;
	// External read seen on the bus, answered a cycle later
	logic device_read = 1'b0;
	scalar_t device_address = '0;

	io_subsystem u_dut(.*);

	always #4 clk = ~clk;

	assign ready_core = ready_index(ia_ready);

	function automatic core_id_t ready_index(input logic [`NUM_CORES-1:0] ready);
		core_id_t idx;
		idx = '0;
		for (int i = 0; i < `NUM_CORES; i++)
			if (ready[i])
				idx = core_id_t'(i);
		return idx;
	endfunction

	function automatic logic internal_address(input scalar_t a);
		return (a >= `PERF_BASE_ADDRESS && a < `PERF_BASE_ADDRESS + 4 * `NUM_PERF_EVENTS)
			|| (a >= `IC_BASE_ADDRESS && a < `IC_BASE_ADDRESS + 8);
	endfunction

	// Word aligned, above both device ranges
	function automatic scalar_t external_address(input scalar_t raw);
		return (raw & 32'h0FFF_FFFC) | 32'h0000_1000;
	endfunction

	function automatic int outstanding_requests();
		int total;
		total = 0;
		for (int i = 0; i < `NUM_CORES; i++)
			total += expected_q[i].size();
		return total;
	endfunction

	task automatic report_mismatch(input string name, input scalar_t got, input scalar_t exp);
		errors++;
		$display("Mismatch %s: got %h, expected %h", name, got, exp);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error: %s", what);
	endtask

	// Raise a request, hold it until the ready pulse
	task automatic core_access(input int core, input logic store, input scalar_t addr,
		input scalar_t data, input scalar_t expected);
		@(negedge clk);
		ior_valid[core] = 1'b1;
		ior_store[core] = store;
		ior_address[core*32 +: 32] = addr;
		ior_write_data[core*32 +: 32] = data;
		issued_store[core] = store;
		issued_addr[core] = addr;
		issued_data[core] = data;
		expected_q[core].push_back(expected);
		do
			@(negedge clk);
		while (!ia_ready[core]);
		ior_valid[core] = 1'b0;
	endtask

	task automatic load_burst(input int core);
		scalar_t addr;
		for (int r = 0; r < FAIR_ROUNDS; r++)
		begin
			addr = 32'h0000_2000 + 32'(core * 'h100 + r * 4);
			core_access(core, 1'b0, addr, '0, addr ^ DEVICE_PATTERN);
		end
	endtask

	task automatic wait_idle();
		while (outstanding_requests() != 0)
			@(negedge clk);
		// Last response check fires at the next rising edge
		@(negedge clk);
	endtask

	// External device, ignores internal addresses and all writes
	// Read data shows up in the cycle after the read strobe
	always @(negedge clk)
	begin
		if (device_read)
			io_read_data = device_address ^ DEVICE_PATTERN;
		device_read = io_read_en && !internal_address(io_address);
		device_address = io_address;
	end

	// Expected value for the response now on the bus
	always @(negedge clk)
	begin
		if (rst_n && ia_response_valid)
		begin
			rsp_known = expected_q[ia_response_core].size() != 0;
			if (rsp_known)
				exp_data = expected_q[ia_response_core].pop_front();
			next_grant = ia_response_core + 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ia_ready))
		else report_failure("ready pulsed for more than one core");
	assert property (@(posedge clk) disable iff (!rst_n) (ia_ready != 0)
		|-> (io_write_en == issued_store[ready_core] && io_read_en == !issued_store[ready_core]))
		else report_failure("bus strobe does not match the granted request");
	assert property (@(posedge clk) disable iff (!rst_n)
		(ia_ready != 0) |-> io_address == issued_addr[ready_core])
		else report_mismatch("io_address", io_address, issued_addr[ready_core]);
	assert property (@(posedge clk) disable iff (!rst_n)
		(ia_ready != 0 && io_write_en) |-> io_write_data == issued_data[ready_core])
		else report_mismatch("io_write_data", io_write_data, issued_data[ready_core]);
	// Response exactly one cycle after the ready pulse
	assert property (@(posedge clk) disable iff (!rst_n)
		ia_response_valid == ($past(ia_ready) != 0))
		else report_failure("response valid not one cycle after the ready pulse");
	assert property (@(posedge clk) disable iff (!rst_n)
		ia_response_valid |-> ia_response_core == $past(ready_core))
		else report_mismatch("ia_response_core", 32'(ia_response_core), 32'($past(ready_core)));
	assert property (@(posedge clk) disable iff (!rst_n) ia_response_valid |-> rsp_known)
		else report_failure("response for a core with no request outstanding");
	assert property (@(posedge clk) disable iff (!rst_n)
		(ia_response_valid && rsp_known) |-> ia_response_data == exp_data)
		else report_mismatch("ia_response_data", ia_response_data, exp_data);
	assert property (@(posedge clk) disable iff (!rst_n)
		(fairness_on && ia_ready != 0) |-> ready_core == next_grant)
		else report_mismatch("ready_core", 32'(ready_core), 32'(next_grant));
	assert property (@(posedge clk) disable iff (!rst_n)
		ic_check |-> interrupt_pending == exp_pending)
		else report_mismatch("interrupt_pending", 32'(interrupt_pending), 32'(exp_pending));
	assert property (@(posedge clk) disable iff (!rst_n) ic_check |-> thread_en == exp_mask)
		else report_mismatch("thread_en", 32'(thread_en), 32'(exp_mask));

	initial
	begin
		while (cycle_count < MAX_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, stimulus never finished", cycle_count);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		scalar_t addr;
		scalar_t data;
		int event_total[`NUM_PERF_EVENTS];
		logic [`TOTAL_THREADS-1:0] req_acc;

		rst_n = 1'b0;
		ior_valid = '0;
		ior_store = '0;
		ior_address = '0;
		ior_write_data = '0;
		interrupt_req = '0;
		interrupt_ack = '0;
		perf_events = '0;
		io_read_data = '0;
		repeat (4)
			@(negedge clk);
		rst_n = 1'b1;

		// External stores, then loads, from random cores
		repeat (6)
		begin
			addr = external_address($random(seed));
			data = $random(seed);
			core_access({$random(seed)} % `NUM_CORES, 1'b1, addr, data, '0);
		end
		repeat (12)
		begin
			addr = external_address($random(seed));
			core_access({$random(seed)} % `NUM_CORES, 1'b0, addr, '0, addr ^ DEVICE_PATTERN);
		end

		// Random event pattern, then read each counter back
		for (int i = 0; i < `NUM_PERF_EVENTS; i++)
			event_total[i] = 0;
		repeat (PERF_CYCLES)
		begin
			@(negedge clk);
			perf_events = $random(seed);
			for (int i = 0; i < `NUM_PERF_EVENTS; i++)
				event_total[i] += int'(perf_events[i]);
		end
		@(negedge clk);
		perf_events = '0;
		for (int i = 0; i < `NUM_PERF_EVENTS; i++)
			core_access({$random(seed)} % `NUM_CORES, 1'b0, `PERF_BASE_ADDRESS + 4 * i, '0,
				event_total[i]);

		// Enable mask write, then random interrupt pulses
		exp_mask = $random(seed);
		core_access(0, 1'b1, `IC_BASE_ADDRESS, scalar_t'(exp_mask), '0);
		req_acc = '0;
		repeat (10)
		begin
			@(negedge clk);
			interrupt_req = $random(seed);
			req_acc |= interrupt_req;
		end
		@(negedge clk);
		interrupt_req = '0;
		exp_pending = req_acc & exp_mask;
		ic_check = 1'b1;
		@(negedge clk);
		ic_check = 1'b0;
		core_access(1, 1'b0, `IC_BASE_ADDRESS + 4, '0, scalar_t'(exp_pending));
		core_access(2, 1'b0, `IC_BASE_ADDRESS, '0, scalar_t'(exp_mask));

		// Acknowledge a random subset of threads
		@(negedge clk);
		interrupt_ack = $random(seed);
		@(negedge clk);
		exp_pending &= ~interrupt_ack;
		interrupt_ack = '0;
		ic_check = 1'b1;
		@(negedge clk);
		ic_check = 1'b0;
		wait_idle();

		// All cores at once, grants must rotate
		fairness_on = 1'b1;
		fork
			load_burst(0);
			load_burst(1);
			load_burst(2);
			load_burst(3);
		join
		fairness_on = 1'b0;
		wait_idle();

		$display("Run finished after %0d cycles with %0d errors", cycle_count, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+.
io_pkg.sv
io_bus_if.sv
io_arbiter.sv
interrupt_controller.sv
performance_counters.sv
io_subsystem.sv
io_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the I/O subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module io_subsystem_tb -f filelist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/Vio_subsystem_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qF 'All tests passed!'; then
	exit 0
fi
exit 1
